//--- common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XLEN 32
`define NREGS 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RESET_PC 32'h0000_0080
`define NOP_INSTR 32'h0000_0013 // addi x0,x0,0.

`endif

//--- common/riscv_pkg.sv
package riscv_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // major opcodes, instr[6:0]
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_fence  = 7'b0001111,
    op_system = 7'b1110011
  } opcode_t;

  // branch compare ops, same code as funct3.
  typedef enum logic [2:0] {
    beq      = 3'b000,
    bne      = 3'b001,
    bcu_none = 3'b010, // funct3 2 is unused by branches.
    blt      = 3'b100,
    bge      = 3'b101,
    bltu     = 3'b110,
    bgeu     = 3'b111
  } bcu_op_t;

  // load/store ops, {store, funct3}.
  typedef enum logic [3:0] {
    lb       = 4'b0000,
    lh       = 4'b0001,
    lw       = 4'b0010,
    lbu      = 4'b0100,
    lhu      = 4'b0101,
    sb       = 4'b1000,
    sh       = 4'b1001,
    sw       = 4'b1010,
    lsu_none = 4'b1111
  } lsu_op_t;

  typedef enum logic [3:0] {
    exc_instr_misaligned = 4'd0,
    exc_load_misaligned  = 4'd4,
    exc_store_misaligned = 4'd6
  } ecause_t;

endpackage

//--- common/pipeline_pkg.sv
`include "core_config.svh"

package pipeline_pkg;
  import riscv_pkg::*;

  // predecoder result.
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] imm;
    logic [4:0]       waddr;
    logic [4:0]       raddr1;
    logic [4:0]       raddr2;
    logic             wren;
    logic             rden1;
    logic             rden2;
    logic             lui;
    logic             auipc;
    logic             jal;
    logic             jalr;
    logic             branch;
    logic             load;
    logic             store;
    logic             fence;
    bcu_op_t          bcu_op;
    lsu_op_t          lsu_op;
  } decode_t;

  typedef struct packed {
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] pc;
    logic             auipc;
    logic             jal;
    logic             jalr;
    logic             branch;
    logic             load;
    logic             store;
    lsu_op_t          lsu_op;
  } agu_in_t;

  typedef struct packed {
    logic [`XLEN-1:0] address;
    logic [3:0]       byteenable;
    logic             exception;
    ecause_t          ecause;
    logic [`XLEN-1:0] etval;
  } agu_out_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic [3:0]       wstrb; // zero on loads.
  } dmem_req_t;

  typedef struct packed {
    logic             en;
    logic [4:0]       addr;
    logic [`XLEN-1:0] data;
  } wb_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // packet to execute
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [4:0]       waddr;
    logic             wren;
    logic             rden1;
    logic             rden2;
    logic             lui;
    logic             auipc;
    logic             jal;
    logic             jalr;
    logic             branch;
    logic             load;
    logic             store;
    logic             fence;
    logic             jump;
    logic [`XLEN-1:0] address;
    logic [3:0]       byteenable;
    bcu_op_t          bcu_op;
    lsu_op_t          lsu_op;
    logic             valid;
    logic             invalid;
    logic             exception;
    ecause_t          ecause;
    logic [`XLEN-1:0] etval;
  } fetch_out_t;

  // stage state: pc plus registered packet.
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    fetch_out_t       dec;
  } fetch_reg_t;

  localparam fetch_out_t fetch_bubble = '{
    instr:   `NOP_INSTR,
    invalid: 1'b1,
    bcu_op:  bcu_none,
    lsu_op:  lsu_none,
    ecause:  exc_instr_misaligned,
    default: '0
  };

endpackage

//--- hdl/branch_unit.sv
`timescale 1ns/100ps
`include "core_config.svh"

module branch_unit import riscv_pkg::*; (
  input  logic [`XLEN-1:0] rdata1,
  input  logic [`XLEN-1:0] rdata2,
  input  bcu_op_t          bcu_op,
  output logic             taken
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq = rdata1 == rdata2;
  assign lt = $signed(rdata1) < $signed(rdata2);
  assign ltu = rdata1 < rdata2;

  always_comb begin
    case (bcu_op)
      beq:     taken = eq;
      bne:     taken = ~eq;
      blt:     taken = lt;
      bge:     taken = ~lt;
      bltu:    taken = ltu;
      bgeu:    taken = ~ltu;
      default: taken = 1'b0; // bcu_none.
    endcase
  end

endmodule

//--- hdl/address_unit.sv
`timescale 1ns/100ps
`include "core_config.svh"

module address_unit import riscv_pkg::*, pipeline_pkg::*; (
  input  agu_in_t  agu_in,
  output agu_out_t agu_out
);

  logic [`XLEN-1:0] base;
  logic [`XLEN-1:0] sum;
  logic [3:0]       byteenable;
  logic             mem_misaligned;

  // register base for jalr and memory ops, pc otherwise.
  assign base = (agu_in.jalr | agu_in.load | agu_in.store) ? agu_in.rdata1 : agu_in.pc;
  assign sum = base + agu_in.imm;

  always_comb begin
    agu_out.address = agu_in.jalr ? {sum[`XLEN-1:1], 1'b0} : sum;

    case (agu_in.lsu_op)
      lb, lbu, sb: begin
        byteenable = 4'b0001 << agu_out.address[1:0];
        mem_misaligned = 1'b0;
      end
      lh, lhu, sh: begin
        byteenable = 4'b0011 << {agu_out.address[1], 1'b0};
        mem_misaligned = agu_out.address[0];
      end
      lw, sw: begin
        byteenable = 4'b1111;
        mem_misaligned = |agu_out.address[1:0];
      end
      default: begin
        byteenable = 4'b0000;
        mem_misaligned = 1'b0;
      end
    endcase
    agu_out.byteenable = byteenable;

    agu_out.exception = 1'b0;
    agu_out.ecause = exc_instr_misaligned;
    if ((agu_in.jal | agu_in.jalr | agu_in.branch) && agu_out.address[1]) begin
      agu_out.exception = 1'b1;
    end else if (agu_in.load && mem_misaligned) begin
      agu_out.exception = 1'b1;
      agu_out.ecause = exc_load_misaligned;
    end else if (agu_in.store && mem_misaligned) begin
      agu_out.exception = 1'b1;
      agu_out.ecause = exc_store_misaligned;
    end
    agu_out.etval = agu_out.address; // faulting address.
  end

endmodule

//--- hdl/register_file.sv
`timescale 1ns/100ps
`include "core_config.svh"

module register_file import pipeline_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       raddr1,
  input  logic [4:0]       raddr2,
  output logic [`XLEN-1:0] rdata1,
  output logic [`XLEN-1:0] rdata2,
  input  wb_t              wb
);

  logic [`XLEN-1:0] regs [1:`NREGS-1]; // x0 is not stored.

  function automatic logic [`XLEN-1:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end else if (wb.en && wb.addr == addr) begin
      return wb.data; // same-cycle write bypass.
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 1; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.addr != 5'd0) begin
      regs[wb.addr] <= wb.data;
    end
  end

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

endmodule

//--- fetch/predecoder.sv
`timescale 1ns/100ps

module predecoder import riscv_pkg::*, pipeline_pkg::*; (
  input  logic [31:0] instr,
  output decode_t     decode
);

  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // immediate formats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    decode = '{bcu_op: bcu_none, lsu_op: lsu_none, default: '0};
    decode.waddr = instr[11:7];
    decode.raddr1 = instr[19:15];
    decode.raddr2 = instr[24:20];

    case (opcode_t'(instr[6:0]))
      op_lui: begin
        decode.valid = 1'b1;
        decode.lui = 1'b1;
        decode.wren = 1'b1;
        decode.imm = imm_u;
      end
      op_auipc: begin
        decode.valid = 1'b1;
        decode.auipc = 1'b1;
        decode.wren = 1'b1;
        decode.imm = imm_u;
      end
      op_jal: begin
        decode.valid = 1'b1;
        decode.jal = 1'b1;
        decode.wren = 1'b1;
        decode.imm = imm_j;
      end
      op_jalr: begin
        decode.valid = funct3 == 3'b000;
        decode.jalr = 1'b1;
        decode.wren = 1'b1;
        decode.rden1 = 1'b1;
        decode.imm = imm_i;
      end
      op_branch: begin
        if (funct3[2:1] != 2'b01) begin // funct3 2 and 3 are reserved.
          decode.valid = 1'b1;
          decode.branch = 1'b1;
          decode.rden1 = 1'b1;
          decode.rden2 = 1'b1;
          decode.imm = imm_b;
          decode.bcu_op = bcu_op_t'(funct3);
        end
      end
      op_load: begin
        if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
          decode.valid = 1'b1;
          decode.load = 1'b1;
          decode.wren = 1'b1;
          decode.rden1 = 1'b1;
          decode.imm = imm_i;
          decode.lsu_op = lsu_op_t'({1'b0, funct3});
        end
      end
      op_store: begin
        if (funct3 < 3'b011) begin
          decode.valid = 1'b1;
          decode.store = 1'b1;
          decode.rden1 = 1'b1;
          decode.rden2 = 1'b1;
          decode.imm = imm_s;
          decode.lsu_op = lsu_op_t'({1'b1, funct3});
        end
      end
      op_imm: begin
        decode.valid = (funct3 != 3'b001 || funct7 == 7'h00) &&
                       (funct3 != 3'b101 || funct7 == 7'h00 || funct7 == 7'h20);
        decode.wren = 1'b1;
        decode.rden1 = 1'b1;
        decode.imm = imm_i;
      end
      op_reg: begin
        decode.valid = funct7 == 7'h00 ||
                       (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        decode.wren = 1'b1;
        decode.rden1 = 1'b1;
        decode.rden2 = 1'b1;
      end
      op_fence: begin
        decode.valid = 1'b1;
        decode.fence = 1'b1;
      end
      op_system: begin
        decode.valid = funct3 == 3'b000; // ecall and ebreak only.
      end
      default: ;
    endcase
  end

endmodule

//--- fetch/fetch_stage.sv
`timescale 1ns/100ps
`include "core_config.svh"

module fetch_stage import riscv_pkg::*, pipeline_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] imem_rdata,
  input  logic             imem_ready,
  input  logic             stall,
  input  logic             trap,
  input  logic [`XLEN-1:0] trap_vector,
  output logic [31:0]      instr,
  input  decode_t          decode,
  output logic [4:0]       raddr1,
  output logic [4:0]       raddr2,
  input  logic [`XLEN-1:0] rdata1,
  input  logic [`XLEN-1:0] rdata2,
  output bcu_op_t          bcu_op,
  input  logic             taken,
  output agu_in_t          agu_in,
  input  agu_out_t         agu_out,
  output logic [`XLEN-1:0] imem_addr,
  output dmem_req_t        dmem,
  output fetch_out_t       dec
);

  fetch_reg_t r;
  fetch_reg_t rin;
  fetch_reg_t v;
  logic       bubble;

  always_comb begin
    v = r;
    bubble = trap | ~imem_ready;

    v.dec = fetch_bubble;
    v.dec.pc = r.pc;
    v.dec.instr = bubble ? `NOP_INSTR : imem_rdata;
    instr = v.dec.instr;

    // take decoded fields only for a live, recognised word.
    if (decode.valid && !bubble && !stall) begin
      v.dec.imm = decode.imm;
      v.dec.waddr = decode.waddr;
      v.dec.wren = decode.wren;
      v.dec.rden1 = decode.rden1;
      v.dec.rden2 = decode.rden2;
      v.dec.lui = decode.lui;
      v.dec.auipc = decode.auipc;
      v.dec.jal = decode.jal;
      v.dec.jalr = decode.jalr;
      v.dec.branch = decode.branch;
      v.dec.load = decode.load;
      v.dec.store = decode.store;
      v.dec.fence = decode.fence;
      v.dec.bcu_op = decode.bcu_op;
      v.dec.lsu_op = decode.lsu_op;
      v.dec.valid = 1'b1;
      v.dec.invalid = 1'b0;
    end

    raddr1 = decode.raddr1;
    raddr2 = decode.raddr2;
    v.dec.rdata1 = rdata1; // bypassed in the register file.
    v.dec.rdata2 = rdata2;

    bcu_op = v.dec.bcu_op;
    v.dec.jump = v.dec.jal | v.dec.jalr | taken;

    agu_in.rdata1 = v.dec.rdata1;
    agu_in.imm = v.dec.imm;
    agu_in.pc = r.pc;
    agu_in.auipc = v.dec.auipc;
    agu_in.jal = v.dec.jal;
    agu_in.jalr = v.dec.jalr;
    agu_in.branch = v.dec.branch;
    agu_in.load = v.dec.load;
    agu_in.store = v.dec.store;
    agu_in.lsu_op = v.dec.lsu_op;

    v.dec.address = agu_out.address;
    v.dec.byteenable = agu_out.byteenable;
    v.dec.exception = agu_out.exception;
    v.dec.ecause = agu_out.ecause;
    v.dec.etval = agu_out.etval;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exception squashing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    if (v.dec.exception) begin
      if (v.dec.load) begin
        v.dec.load = 1'b0;
        v.dec.wren = 1'b0;
      end else if (v.dec.store) begin
        v.dec.store = 1'b0;
      end else if (v.dec.jump) begin
        v.dec.jump = 1'b0;
        v.dec.wren = 1'b0;
      end else begin
        v.dec.exception = 1'b0; // not-taken branch to a bad target.
      end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next pc
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    if (trap) begin
      v.pc = trap_vector;
    end else if (!imem_ready) begin
      v.pc = r.pc;
    end else if (v.dec.jump) begin
      v.pc = v.dec.address;
    end else begin
      v.pc = r.pc + `XLEN'd4;
    end

    dmem.valid = v.dec.load | v.dec.store;
    dmem.addr = v.dec.address;
    case (v.dec.lsu_op)
      sb:      dmem.wdata = {4{rdata2[7:0]}};
      sh:      dmem.wdata = {2{rdata2[15:0]}};
      default: dmem.wdata = rdata2;
    endcase
    dmem.wstrb = v.dec.store ? v.dec.byteenable : 4'h0;

    if (trap) begin
      rin = v;
    end else if (stall) begin
      rin = r; // execute not ready, hold.
    end else begin
      rin = v;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r.pc <= `RESET_PC;
      r.dec <= fetch_bubble;
    end else begin
      r <= rin;
    end
  end

  assign imem_addr = r.pc;
  assign dec = r.dec;

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/100ps
`include "core_config.svh"

module fetch_top import riscv_pkg::*, pipeline_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] imem_rdata,
  input  logic             imem_ready,
  input  logic             stall,
  input  logic             trap,
  input  logic [`XLEN-1:0] trap_vector,
  input  wb_t              wb,
  output logic [`XLEN-1:0] imem_addr,
  output dmem_req_t        dmem,
  output fetch_out_t       dec
);

  logic [31:0]      instr;
  decode_t          decode;
  logic [4:0]       raddr1;
  logic [4:0]       raddr2;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  bcu_op_t          bcu_op;
  logic             taken;
  agu_in_t          agu_in;
  agu_out_t         agu_out;

  fetch_stage u_fetch_stage (
    .clk         (clk),
    .rst         (rst),
    .imem_rdata  (imem_rdata),
    .imem_ready  (imem_ready),
    .stall       (stall),
    .trap        (trap),
    .trap_vector (trap_vector),
    .instr       (instr),
    .decode      (decode),
    .raddr1      (raddr1),
    .raddr2      (raddr2),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .bcu_op      (bcu_op),
    .taken       (taken),
    .agu_in      (agu_in),
    .agu_out     (agu_out),
    .imem_addr   (imem_addr),
    .dmem        (dmem),
    .dec         (dec)
  );

  predecoder u_predecoder (
    .instr  (instr),
    .decode (decode)
  );

  branch_unit u_branch_unit (
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .bcu_op (bcu_op),
    .taken  (taken)
  );

  address_unit u_address_unit (
    .agu_in  (agu_in),
    .agu_out (agu_out)
  );

  register_file u_register_file (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wb     (wb)
  );

endmodule

//--- verification/fetch_tb.sv
`timescale 1ns/100ps
`include "core_config.svh"

module fetch_tb import riscv_pkg::*, pipeline_pkg::*;;

  localparam int num_tests = 6;
  localparam int test_cycles = 200;
  localparam int clk_period = 8;

  logic             clk = 1'b0;
  logic             rst;
  logic [`XLEN-1:0] imem_rdata;
  logic             imem_ready;
  logic             stall;
  logic             trap;
  logic [`XLEN-1:0] trap_vector;
  wb_t              wb;
  logic [`XLEN-1:0] imem_addr;
  dmem_req_t        dmem;
  fetch_out_t       dec;

  logic [31:0] imem [0:255]; // covers 0x000 to 0x3ff.
  int          errors = 0;
  int          requests = 0;
  int          seed = 32'h9e4758d0;

  fetch_top UUT (
    .clk         (clk),
    .rst         (rst),
    .imem_rdata  (imem_rdata),
    .imem_ready  (imem_ready),
    .stall       (stall),
    .trap        (trap),
    .trap_vector (trap_vector),
    .wb          (wb),
    .imem_addr   (imem_addr),
    .dmem        (dmem),
    .dec         (dec)
  );

  always #(clk_period / 2) clk = ~clk;

  // same-cycle answer, nop outside the array.
  assign imem_rdata = (imem_addr < 32'h400) ? imem[imem_addr[9:2]] : `NOP_INSTR;

  // data-request monitor.
  always @(negedge clk) begin
    if (rst && dmem.valid) begin
      requests++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction encoders
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] i_type(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                         logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // rv32i branch conditions.
  function automatic logic expect_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check_value(string test, string what, logic [31:0] expected,
                             logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s: expected %h, actual %h", test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic clear_program();
    logic [31:0] addr;
    for (int i = 0; i < 256; i++) begin
      addr = 4 * i;
      imem[i] = i_type(op_imm, 5'd0, 3'b000, 5'd0, addr[11:0]); // addi x0,x0,addr.
    end
  endtask

  task automatic load_word(logic [31:0] addr, logic [31:0] word);
    imem[addr[9:2]] = word;
  endtask

  // returns on the edge where rst goes high.
  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b0;
    stall <= 1'b0;
    imem_ready <= 1'b1;
    trap <= 1'b0;
    trap_vector <= '0;
    wb <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_sequential();
    logic [31:0] words [4];
    logic [31:0] imms [4];
    logic [4:0]  rds [4];
    words[0] = i_type(op_imm, 5'd1, 3'b000, 5'd0, 12'd5);
    imms[0] = 32'd5;
    rds[0] = 5'd1;
    words[1] = u_type(op_lui, 5'd2, 20'h12345);
    imms[1] = 32'h1234_5000;
    rds[1] = 5'd2;
    words[2] = i_type(op_imm, 5'd3, 3'b000, 5'd1, 12'hff9); // addi x3,x1,-7.
    imms[2] = 32'hffff_fff9;
    rds[2] = 5'd3;
    words[3] = u_type(op_lui, 5'd4, 20'hfffff);
    imms[3] = 32'hffff_f000;
    rds[3] = 5'd4;
    clear_program();
    for (int i = 0; i < 4; i++) begin
      load_word(`RESET_PC + 4 * i, words[i]);
    end
    apply_reset();
    @(negedge clk);
    check_value("sequential", "reset pc", `RESET_PC, imem_addr);
    check_value("sequential", "reset bubble", 1, dec.invalid);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_value("sequential", "imem_addr", `RESET_PC + 4 * (i + 1), imem_addr);
      check_value("sequential", "dec.pc", `RESET_PC + 4 * i, dec.pc);
      check_value("sequential", "dec.instr", words[i], dec.instr);
      check_value("sequential", "dec.waddr", rds[i], dec.waddr);
      check_value("sequential", "dec.wren", 1, dec.wren);
      check_value("sequential", "dec.imm", imms[i], dec.imm);
      check_value("sequential", "dec.valid", 1, dec.valid);
    end
  endtask

  task automatic test_jumps();
    clear_program();
    load_word(32'h80, j_type(5'd1, 21'd16));
    load_word(32'h90, i_type(op_jalr, 5'd5, 3'b000, 5'd2, 12'd3));
    load_word(32'h204, j_type(5'd0, 21'd6)); // target 0x20a, not word aligned.
    apply_reset();
    wb <= '{en: 1'b1, addr: 5'd2, data: 32'h201};
    @(posedge clk);
    wb <= '0;
    @(negedge clk);
    check_value("jumps", "jal target", 32'h90, imem_addr);
    check_value("jumps", "jal dec.jump", 1, dec.jump);
    @(negedge clk);
    check_value("jumps", "jalr target", 32'h204, imem_addr);
    check_value("jumps", "jalr dec.jump", 1, dec.jump);
    @(negedge clk);
    check_value("jumps", "misaligned next pc", 32'h208, imem_addr);
    check_value("jumps", "dec.exception", 1, dec.exception);
    check_value("jumps", "dec.ecause", exc_instr_misaligned, dec.ecause);
    check_value("jumps", "dec.etval", 32'h20a, dec.etval);
    check_value("jumps", "cancelled jump", 0, dec.jump);
  endtask

  task automatic test_branches();
    logic [2:0]  ops [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    string       names [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] target;
    for (int k = 0; k < 6; k++) begin
      a = $random(seed);
      b = (k % 3 == 0) ? a : $random(seed); // equal operands now and then.
      target = expect_taken(ops[k], a, b) ? 32'ha4 : 32'h88;
      clear_program();
      load_word(32'h84, b_type(ops[k], 5'd6, 5'd7, 13'd32));
      apply_reset();
      wb <= '{en: 1'b1, addr: 5'd6, data: a};
      @(posedge clk);
      wb <= '{en: 1'b1, addr: 5'd7, data: b}; // read through the bypass.
      @(posedge clk);
      wb <= '0;
      @(negedge clk);
      check_value("branches", names[k], target, imem_addr);
      check_value("branches", "dec.branch", 1, dec.branch);
      check_value("branches", "dec.rdata1", a, dec.rdata1);
      check_value("branches", "dec.rdata2", b, dec.rdata2);
    end
  endtask

  task automatic test_memory();
    logic [31:0] d;
    d = $random(seed);
    clear_program();
    load_word(32'h88, s_type(3'b010, 5'd8, 5'd9, 12'd4));
    load_word(32'h8c, s_type(3'b001, 5'd8, 5'd9, 12'd6));
    load_word(32'h90, s_type(3'b000, 5'd8, 5'd9, 12'd3));
    load_word(32'h94, i_type(op_load, 5'd10, 3'b010, 5'd8, 12'd8));
    load_word(32'h98, i_type(op_load, 5'd11, 3'b010, 5'd8, 12'd2));
    apply_reset();
    requests = 0;
    wb <= '{en: 1'b1, addr: 5'd8, data: 32'h1000};
    @(posedge clk);
    wb <= '{en: 1'b1, addr: 5'd9, data: d};
    @(posedge clk);
    wb <= '0;
    @(negedge clk);
    check_value("memory", "sw valid", 1, dmem.valid);
    check_value("memory", "sw addr", 32'h1004, dmem.addr);
    check_value("memory", "sw wstrb", 4'b1111, dmem.wstrb);
    check_value("memory", "sw wdata", d, dmem.wdata);
    @(negedge clk);
    check_value("memory", "sh addr", 32'h1006, dmem.addr);
    check_value("memory", "sh wstrb", 4'b1100, dmem.wstrb);
    check_value("memory", "sh wdata", {2{d[15:0]}}, dmem.wdata);
    @(negedge clk);
    check_value("memory", "sb addr", 32'h1003, dmem.addr);
    check_value("memory", "sb wstrb", 4'b1000, dmem.wstrb);
    check_value("memory", "sb wdata", {4{d[7:0]}}, dmem.wdata);
    @(negedge clk);
    check_value("memory", "lw valid", 1, dmem.valid);
    check_value("memory", "lw addr", 32'h1008, dmem.addr);
    check_value("memory", "lw wstrb", 0, dmem.wstrb);
    @(negedge clk);
    check_value("memory", "misaligned lw valid", 0, dmem.valid);
    @(negedge clk);
    check_value("memory", "dec.exception", 1, dec.exception);
    check_value("memory", "dec.ecause", exc_load_misaligned, dec.ecause);
    check_value("memory", "dec.etval", 32'h1002, dec.etval);
    check_value("memory", "next pc", 32'h9c, imem_addr);
    @(posedge clk);
    check_value("memory", "request count", 4, requests);
  endtask

  task automatic test_stall_ready();
    clear_program();
    load_word(32'h80, i_type(op_imm, 5'd1, 3'b000, 5'd0, 12'd1));
    load_word(32'h84, s_type(3'b010, 5'd0, 5'd0, 12'd16));
    load_word(32'h88, i_type(op_imm, 5'd2, 3'b000, 5'd0, 12'd2));
    apply_reset();
    @(posedge clk);
    stall <= 1'b1;
    @(negedge clk);
    check_value("stall", "dmem.valid", 0, dmem.valid);
    @(negedge clk);
    check_value("stall", "held pc", 32'h84, imem_addr);
    check_value("stall", "held dec.pc", 32'h80, dec.pc);
    check_value("stall", "dmem.valid", 0, dmem.valid);
    @(posedge clk);
    stall <= 1'b0;
    @(negedge clk);
    check_value("stall", "released pc", 32'h84, imem_addr);
    check_value("stall", "store request", 1, dmem.valid);
    @(posedge clk);
    imem_ready <= 1'b0;
    @(negedge clk);
    check_value("stall", "dec.store", 1, dec.store);
    @(negedge clk);
    check_value("not ready", "held pc", 32'h88, imem_addr);
    check_value("not ready", "dec.invalid", 1, dec.invalid);
    check_value("not ready", "dec.valid", 0, dec.valid);
    @(posedge clk);
    imem_ready <= 1'b1;
    @(negedge clk);
    check_value("not ready", "last held pc", 32'h88, imem_addr);
    @(negedge clk);
    check_value("not ready", "resumed pc", 32'h8c, imem_addr);
    check_value("not ready", "dec.pc", 32'h88, dec.pc);
    check_value("not ready", "dec.invalid", 0, dec.invalid);
  endtask

  task automatic test_trap();
    clear_program();
    load_word(32'h80, j_type(5'd0, 21'd64)); // jal loses to the trap.
    load_word(32'h300, i_type(op_imm, 5'd1, 3'b000, 5'd0, 12'd1));
    apply_reset();
    trap <= 1'b1;
    trap_vector <= 32'h300;
    @(posedge clk);
    trap <= 1'b0;
    @(negedge clk);
    check_value("trap", "vector pc", 32'h300, imem_addr);
    check_value("trap", "dec.invalid", 1, dec.invalid);
    check_value("trap", "dec.valid", 0, dec.valid);
    check_value("trap", "dec.jump", 0, dec.jump);
    @(negedge clk);
    check_value("trap", "pc after vector", 32'h304, imem_addr);
    check_value("trap", "dec.pc", 32'h300, dec.pc);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // run and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst <= 1'b0;
    stall <= 1'b0;
    imem_ready <= 1'b1;
    trap <= 1'b0;
    trap_vector <= '0;
    wb <= '0;
    test_sequential();
    test_jumps();
    test_branches();
    test_memory();
    test_stall_ready();
    test_trap();
    repeat (2) @(posedge clk);
    $display("%0d tests run, %0d errors", num_tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(num_tests * test_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
common/riscv_pkg.sv
common/pipeline_pkg.sv
hdl/branch_unit.sv
hdl/address_unit.sv
hdl/register_file.sv
fetch/predecoder.sv
fetch/fetch_stage.sv
hdl/fetch_top.sv
verification/fetch_tb.sv
